// ==== common/cache_test_pkg.sv ====
`default_nettype none

package cache_test_pkg;

  typedef logic [35:0]  addr_t;   // Byte address
  typedef logic [127:0] line_t;   // One line or one memory beat

  // Write types
  typedef logic [1:0] wtype_t;
  localparam wtype_t WT_NONE = 2'b00;
  localparam wtype_t WT_FULL = 2'b01;
  localparam wtype_t WT_HIGH = 2'b10;   // Bits 127..64
  localparam wtype_t WT_LOW  = 2'b11;   // Bits 63..0

  // Flush types
  typedef logic [1:0] ftype_t;
  localparam ftype_t FT_NONE      = 2'b00;
  localparam ftype_t FT_WRITEBACK = 2'b10;

  typedef enum logic [3:0] {
    idle,
    evict_req,
    evict_wait,
    fill_req,
    fill_wait,
    flush_scan,
    flush_req,
    flush_wait,
    flush_done
  } cache_state_t;

endpackage

`default_nettype wire

// ==== tester/cache_tester_sm.sv ====
`default_nettype none

module cache_tester_sm import cache_test_pkg::*; #(
  parameter int test_lines = 16
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   go,
  input  wire addr_t  wr_offset,
  input  wire logic   mem_stall,
  input  wire line_t  cache_data,
  output addr_t       addr,
  output logic        r,
  output wtype_t      w_type,
  output line_t       wr_data,
  output ftype_t      flushtype,
  output logic        done
);

  localparam int idx_bits = $clog2(test_lines);
  localparam int ctr_w    = idx_bits + 2;   // Phase bit, index, end flag

  logic [ctr_w-1:0]    ctr_q;
  logic [idx_bits-1:0] idx;
  logic                start_q;
  logic                done_q;
  logic                walk_end;
  logic                hold_q;
  addr_t               wr_offset_q;
  addr_t               line_off;

  // Fresh request values
  addr_t  addr_new;
  logic   r_new;
  wtype_t w_type_new;
  ftype_t flushtype_new;

  // Copies of last cycle's outputs
  addr_t  addr_held;
  logic   r_held;
  wtype_t w_type_held;
  line_t  wr_data_held;
  ftype_t flushtype_held;

  logic req_present;
  logic req_done;

  assign idx      = ctr_q[ctr_w-2:1];
  assign walk_end = ctr_q[ctr_w-1];
  assign line_off = addr_t'(idx) << 4;

  // ##################################################
  // Request decode from the counter
  assign r_new         = start_q & ~walk_end & ~ctr_q[0];
  assign addr_new      = ctr_q[0] ? wr_offset_q + line_off : line_off;
  assign flushtype_new = (start_q & walk_end & ~done_q) ? FT_WRITEBACK : FT_NONE;

  always_comb begin
    if (!(start_q && !walk_end && ctr_q[0])) begin
      w_type_new = WT_NONE;
    end else if (!idx[idx_bits-1]) begin
      w_type_new = WT_FULL;   // First half
    end else if (!idx[idx_bits-2]) begin
      w_type_new = WT_HIGH;   // Third quarter
    end else begin
      w_type_new = WT_LOW;
    end
  end

  // Hold the request that stalled last cycle
  assign addr      = hold_q ? addr_held      : addr_new;
  assign r         = hold_q ? r_held         : r_new;
  assign w_type    = hold_q ? w_type_held    : w_type_new;
  assign wr_data   = hold_q ? wr_data_held   : cache_data;
  assign flushtype = hold_q ? flushtype_held : flushtype_new;
  assign done      = done_q;

  assign req_present = r | (w_type != WT_NONE) | (flushtype == FT_WRITEBACK);
  assign req_done    = req_present & ~mem_stall;

  // ##################################################
  // Counter and run control
  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      hold_q  <= 1'b0;
      ctr_q   <= '0;
    end else begin
      hold_q <= req_present & mem_stall;
      if (go && !start_q) begin
        start_q <= 1'b1;
      end
      if (req_done) begin
        if (walk_end) begin
          done_q <= 1'b1;   // Flush finished
        end else begin
          ctr_q <= ctr_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go && !start_q) begin
      wr_offset_q <= wr_offset;
    end
    addr_held      <= addr;
    r_held         <= r;
    w_type_held    <= w_type;
    wr_data_held   <= wr_data;
    flushtype_held <= flushtype;
  end

endmodule

`default_nettype wire

// ==== cache/cache_array.sv ====
`default_nettype none

module cache_array import cache_test_pkg::*; #(
  parameter int cache_sets = 8
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [$clog2(cache_sets)-1:0] set_idx,
  input  wire logic                          wr_en,
  input  wire addr_t                         wr_tag,
  input  wire line_t                         wr_line,
  input  wire logic                          wr_dirty,
  output logic                               rd_valid,
  output logic                               rd_dirty,
  output addr_t                              rd_tag,
  output line_t                              rd_line
);

  logic [cache_sets-1:0] valid_q;
  logic [cache_sets-1:0] dirty_q;
  addr_t                 tag_mem  [cache_sets];
  line_t                 data_mem [cache_sets];

  // Status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;   // Cache starts empty
      dirty_q <= '0;
    end else if (wr_en) begin
      valid_q[set_idx] <= 1'b1;
      dirty_q[set_idx] <= wr_dirty;
    end
  end

  // Tag and line storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[set_idx]  <= wr_tag;
      data_mem[set_idx] <= wr_line;
    end
  end

  // Combinational read port
  assign rd_valid = valid_q[set_idx];
  assign rd_dirty = dirty_q[set_idx];
  assign rd_tag   = tag_mem[set_idx];
  assign rd_line  = data_mem[set_idx];

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl import cache_test_pkg::*; #(
  parameter int cache_sets = 8
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // Tester side
  input  wire addr_t                         addr,
  input  wire logic                          r,
  input  wire wtype_t                        w_type,
  input  wire line_t                         wr_data,
  input  wire ftype_t                        flushtype,
  output logic                               mem_stall,
  output line_t                              cache_data,
  // Array side
  output logic [$clog2(cache_sets)-1:0]      set_idx,
  output logic                               wr_en,
  output addr_t                              wr_tag,
  output line_t                              wr_line,
  output logic                               wr_dirty,
  input  wire logic                          rd_valid,
  input  wire logic                          rd_dirty,
  input  wire addr_t                         rd_tag,
  input  wire line_t                         rd_line,
  // Memory side
  output logic                               mem_req,
  output logic                               mem_we,
  output addr_t                              mem_addr,
  output line_t                              mem_wdata,
  input  wire logic                          mem_ack,
  input  wire line_t                         mem_rdata
);

  localparam int set_bits = $clog2(cache_sets);
  localparam int tag_lsb  = 4 + set_bits;

  cache_state_t        state;
  logic [set_bits-1:0] flush_ptr;
  logic                ptr_last;
  logic                in_flush;
  logic                rd_req, wr_req, fl_req, req_present;
  logic                hit, hit_done, flush_complete;
  logic                load_wb;
  addr_t               req_tag, req_line_addr, victim_addr;
  line_t               merged;
  logic                mem_req_q, mem_we_q;
  addr_t               mem_addr_q;
  line_t               mem_wdata_q, cache_data_q;

  function automatic line_t merge_line(line_t old_line, line_t new_data, wtype_t wt);
    line_t res;
    case (wt)
      WT_FULL: res = new_data;
      WT_HIGH: res = {new_data[127:64], old_line[63:0]};
      WT_LOW:  res = {old_line[127:64], new_data[63:0]};
      default: res = old_line;
    endcase
    return res;
  endfunction

  // ##################################################
  // Request decode and hit check
  assign rd_req      = r;
  assign wr_req      = (w_type != WT_NONE);
  assign fl_req      = (flushtype == FT_WRITEBACK);
  assign req_present = rd_req | wr_req | fl_req;

  assign in_flush = (state inside {flush_scan, flush_req, flush_wait, flush_done});
  assign set_idx  = in_flush ? flush_ptr : addr[4 +: set_bits];
  assign ptr_last = (flush_ptr == set_bits'(cache_sets - 1));

  assign req_tag       = addr >> tag_lsb;
  assign req_line_addr = {addr[35:4], 4'h0};
  assign victim_addr   = (rd_tag << tag_lsb) | (addr_t'(set_idx) << 4);
  assign hit           = rd_valid && (rd_tag == req_tag);
  assign merged        = merge_line(rd_line, wr_data, w_type);

  assign hit_done       = (state == idle) && !fl_req && (rd_req || wr_req) && hit;
  assign flush_complete = (state == flush_done) && fl_req && !mem_ack;
  assign mem_stall      = req_present && !(hit_done || flush_complete);   // Comb

  // Array write port
  always_comb begin
    wr_en    = 1'b0;
    wr_tag   = req_tag;
    wr_line  = merged;
    wr_dirty = 1'b1;
    case (state)
      idle: wr_en = hit_done && wr_req;
      fill_wait: begin
        wr_en    = mem_ack;   // Fill arrives clean
        wr_line  = mem_rdata;
        wr_dirty = 1'b0;
      end
      flush_wait: begin
        wr_en    = mem_ack;
        wr_tag   = rd_tag;
        wr_line  = rd_line;
        wr_dirty = 1'b0;
      end
      default: wr_en = 1'b0;
    endcase
  end

  // ##################################################
  // Controller FSM and four-phase master
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      mem_req_q <= 1'b0;
      mem_we_q  <= 1'b0;
      flush_ptr <= '0;
    end else begin
      case (state)
        idle: begin
          if (fl_req) begin
            state     <= flush_scan;
            flush_ptr <= '0;
          end else if ((rd_req || wr_req) && !hit) begin
            state <= (rd_valid && rd_dirty) ? evict_req : fill_req;
          end
        end
        evict_req, flush_req: begin
          if (!mem_ack) begin   // Previous handshake fully closed
            mem_req_q <= 1'b1;
            mem_we_q  <= 1'b1;
            state     <= (state == evict_req) ? evict_wait : flush_wait;
          end
        end
        evict_wait: begin
          if (mem_ack) begin
            mem_req_q <= 1'b0;
            mem_we_q  <= 1'b0;
            state     <= fill_req;
          end
        end
        fill_req: begin
          if (!mem_ack) begin
            mem_req_q <= 1'b1;
            mem_we_q  <= 1'b0;
            state     <= fill_wait;
          end
        end
        fill_wait: begin
          if (mem_ack) begin
            mem_req_q <= 1'b0;
            state     <= idle;   // Request hits next cycle
          end
        end
        flush_scan: begin
          if (rd_valid && rd_dirty) begin
            state <= flush_req;
          end else if (ptr_last) begin
            state <= flush_done;
          end else begin
            flush_ptr <= flush_ptr + 1'b1;
          end
        end
        flush_wait: begin
          if (mem_ack) begin
            mem_req_q <= 1'b0;
            mem_we_q  <= 1'b0;
            if (ptr_last) begin
              state <= flush_done;
            end else begin
              flush_ptr <= flush_ptr + 1'b1;
              state     <= flush_scan;
            end
          end
        end
        flush_done: if (flush_complete) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Memory payload and read data
  assign load_wb = (state == evict_req || state == flush_req) && !mem_ack;

  always_ff @(posedge clk) begin
    if (load_wb) begin
      mem_addr_q  <= victim_addr;
      mem_wdata_q <= rd_line;
    end else if (state == fill_req && !mem_ack) begin
      mem_addr_q <= req_line_addr;
    end
    if (hit_done && rd_req) begin
      cache_data_q <= rd_line;
    end
  end

  assign mem_req    = mem_req_q;
  assign mem_we     = mem_we_q;
  assign mem_addr   = mem_addr_q;
  assign mem_wdata  = mem_wdata_q;
  assign cache_data = cache_data_q;

endmodule

`default_nettype wire

// ==== logic/cache_test_top.sv ====
`default_nettype none

module cache_test_top import cache_test_pkg::*; #(
  parameter int test_lines = 16,
  parameter int cache_sets = 8
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  go,
  input  wire addr_t wr_offset,
  output logic       done,
  // Main memory bus
  output logic       mem_req,
  output logic       mem_we,
  output addr_t      mem_addr,
  output line_t      mem_wdata,
  input  wire logic  mem_ack,
  input  wire line_t mem_rdata
);

  localparam int set_bits = $clog2(cache_sets);

  // Tester to cache
  addr_t  addr;
  logic   r;
  wtype_t w_type;
  line_t  wr_data;
  ftype_t flushtype;
  logic   mem_stall;
  line_t  cache_data;

  // Controller to array
  logic [set_bits-1:0] set_idx;
  logic                wr_en, wr_dirty;
  addr_t               wr_tag, rd_tag;
  line_t               wr_line, rd_line;
  logic                rd_valid, rd_dirty;

  cache_tester_sm #(.test_lines(test_lines)) tester_i (
    .clk, .rst, .go, .wr_offset, .mem_stall, .cache_data,
    .addr, .r, .w_type, .wr_data, .flushtype, .done
  );

  cache_ctrl #(.cache_sets(cache_sets)) ctrl_i (
    .clk, .rst,
    .addr, .r, .w_type, .wr_data, .flushtype, .mem_stall, .cache_data,
    .set_idx, .wr_en, .wr_tag, .wr_line, .wr_dirty,
    .rd_valid, .rd_dirty, .rd_tag, .rd_line,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  cache_array #(.cache_sets(cache_sets)) array_i (
    .clk, .rst, .set_idx, .wr_en, .wr_tag, .wr_line, .wr_dirty,
    .rd_valid, .rd_dirty, .rd_tag, .rd_line
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns period
  end

  // Power-on reset over the first 3 rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model import cache_test_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  mem_req,
  input  wire logic  mem_we,
  input  wire addr_t mem_addr,
  input  wire line_t mem_wdata,
  output logic       mem_ack,
  output line_t      mem_rdata,
  output logic       viol,       // Sticky flag for a bad handshake
  output int         hs_count    // Acknowledged requests
);

  timeunit 1ns;
  timeprecision 100ps;

  line_t lines [addr_t];   // Only lines that were written
  int    seed;
  int    delay_left;
  logic  in_reset;
  logic  req_seen;         // Request level before the last edge
  logic  we_hold;
  addr_t addr_hold;
  line_t wdata_hold;

  // Never written lines read back a pattern of their address
  function automatic line_t fill_line(addr_t a);
    return {a, ~a, a[35:4] ^ 32'h6C8E_9CF5, 24'hB45A3C};
  endfunction

  function automatic line_t peek(addr_t a);
    return lines.exists(a) ? lines[a] : fill_line(a);
  endfunction

  task automatic poke(addr_t a, line_t d);
    lines[a] = d;
  endtask

  task automatic clear();
    lines.delete();
  endtask

  task automatic flag(string what);
    $display("Memory bus error at %0t ns: %s", $time, what);
    viol = 1'b1;
  endtask

  initial begin
    seed       = 90;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    viol       = 1'b0;
    hs_count   = 0;
    in_reset   = 1'b0;
    req_seen   = 1'b0;
    delay_left = 0;
  end

  // ##################################################
  // Handshake checks on the levels before the edge
  always @(posedge clk) begin
    in_reset = rst;
    if (rst) begin
      req_seen = 1'b0;   // A reset may cut a handshake short
    end else begin
      if (mem_req && !req_seen) begin
        if (mem_ack) flag("request was raised while acknowledge was still high");
        if (mem_addr[3:0] != 4'h0) flag("request address is not line aligned");
        addr_hold  = mem_addr;
        we_hold    = mem_we;
        wdata_hold = mem_wdata;
        delay_left = $unsigned($random(seed)) % 4;   // 0 to 3 cycles
      end else if (mem_req && !mem_ack) begin
        if (mem_addr !== addr_hold || mem_we !== we_hold ||
            (we_hold && mem_wdata !== wdata_hold)) begin
          flag("request changed before it was acknowledged");
        end
      end else if (!mem_req && req_seen && !mem_ack) begin
        flag("request was dropped before it was acknowledged");
      end
      req_seen = mem_req;
    end

    // ##################################################
    // Slave response after the edge
    #1;
    if (in_reset || (mem_ack && !req_seen)) begin
      mem_ack = 1'b0;
    end else if (req_seen && !mem_ack) begin
      if (delay_left > 0) begin
        delay_left--;
      end else begin
        if (we_hold) begin
          lines[addr_hold] = wdata_hold;
        end else begin
          mem_rdata = peek(addr_hold);
        end
        mem_ack = 1'b1;
        hs_count++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/cache_test_tb.sv ====
`default_nettype none

module cache_test_tb import cache_test_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    test_lines      = 16;
  localparam int    cache_sets      = 8;
  localparam int    clk_period      = 10;
  localparam int    cycles_per_line = 200;
  localparam int    run_count       = 6;   // One run is cut short by reset
  localparam int    guard_lines     = 4;   // Checked lines past the destination
  localparam addr_t src_base        = '0;

  logic  clk, por_rst, soft_rst, rst;
  logic  go, done;
  addr_t wr_offset;
  logic  mem_req, mem_we, mem_ack;
  addr_t mem_addr;
  line_t mem_wdata, mem_rdata;
  logic  viol;
  int    hs_count;

  assign rst = por_rst | soft_rst;

  tb_clock_gen clock_i (.clk, .rst(por_rst));

  tb_mem_model mem_i (
    .clk, .rst, .mem_req, .mem_we, .mem_addr, .mem_wdata,
    .mem_ack, .mem_rdata, .viol, .hs_count
  );

  cache_test_top #(
    .test_lines(test_lines),
    .cache_sets(cache_sets)
  ) cache_test_top_i (
    .clk, .rst, .go, .wr_offset, .done,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
  );

  // ##################################################
  // Patterns and expected memory contents
  function automatic addr_t line_at(addr_t base, int i);
    return base + (addr_t'(i) << 4);
  endfunction

  function automatic line_t src_line(int i);
    return {32'h5100_0000 + i, 32'h5200_0000 + i, 32'h5300_0000 + i, 32'h5400_0000 + i};
  endfunction

  function automatic line_t old_line(addr_t a);
    return {a[35:4] ^ 32'hD00D_F00D, a[31:0], ~a[35:4], 16'hFEED, a[15:0]};
  endfunction

  function automatic line_t expect_dest(int i, addr_t a);
    line_t src;
    line_t old;
    src = src_line(i);
    old = old_line(a);
    if (i < test_lines / 2) return src;
    else if (i < test_lines * 3 / 4) return {src[127:64], old[63:0]};   // Upper half only
    else return {old[127:64], src[63:0]};
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_values(string name, line_t expected, line_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch in %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // ##################################################
  // Run control
  task automatic apply_reset();
    @(posedge clk);
    #1 soft_rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 soft_rst = 1'b0;
  endtask

  task automatic preload(addr_t offset);
    addr_t a;
    mem_i.clear();
    for (int i = 0; i < test_lines; i++) begin
      mem_i.poke(line_at(src_base, i), src_line(i));
    end
    for (int i = 0; i < test_lines + guard_lines; i++) begin
      a = line_at(offset, i);
      mem_i.poke(a, old_line(a));
    end
  endtask

  task automatic start_run(addr_t offset);
    @(posedge clk);
    #1;
    wr_offset = offset;
    go        = 1'b1;
    @(posedge clk);
    #1 go = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
      n++;
      if (n > test_lines * cycles_per_line) abort_run("timed out waiting for done");
    end
  endtask

  task automatic copy_run(addr_t offset);
    apply_reset();
    preload(offset);
    start_run(offset);
    wait_done();
  endtask

  task automatic check_dest(string name, addr_t offset, int lo, int hi);
    addr_t a;
    for (int i = lo; i < hi; i++) begin
      a = line_at(offset, i);
      compare_values($sformatf("%s line %0d", name, i), expect_dest(i, a), mem_i.peek(a));
    end
  endtask

  task automatic check_untouched(string name, addr_t offset);
    addr_t a;
    for (int i = 0; i < test_lines; i++) begin
      a = line_at(src_base, i);
      compare_values($sformatf("%s source %0d", name, i), src_line(i), mem_i.peek(a));
    end
    for (int i = test_lines; i < test_lines + guard_lines; i++) begin
      a = line_at(offset, i);
      compare_values($sformatf("%s guard %0d", name, i), old_line(a), mem_i.peek(a));
    end
  endtask

  // ##################################################
  // Directed tests
  task automatic test_full_copy();
    copy_run(36'h1000);
    check_dest("full_copy", 36'h1000, 0, test_lines / 2);
  endtask

  task automatic test_high_merge();
    copy_run(36'h1480);
    check_dest("high_merge", 36'h1480, test_lines / 2, test_lines * 3 / 4);
  endtask

  task automatic test_low_merge();
    copy_run(36'h20C0);
    check_dest("low_merge", 36'h20C0, test_lines * 3 / 4, test_lines);
  endtask

  task automatic test_untouched();
    copy_run(36'h3000);
    check_untouched("untouched", 36'h3000);
    compare_values("untouched mem_req at done", '0, line_t'(mem_req));
    repeat (20) begin
      @(posedge clk);
      #1;
      compare_values("untouched mem_req after done", '0, line_t'(mem_req));
    end
  endtask

  task automatic test_reset_rerun();
    int hs_mark;
    int n;
    n = 0;
    apply_reset();
    preload(36'h4000);
    start_run(36'h4000);
    hs_mark = hs_count + 5;
    while (hs_count < hs_mark) begin
      @(posedge clk);
      n++;
      if (n > test_lines * cycles_per_line) abort_run("no memory traffic before the reset");
    end
    if (done) abort_run("first run ended before it could be reset");
    apply_reset();   // Cuts the first run short
    hs_mark = hs_count;
    preload(36'h5A40);
    start_run(36'h5A40);
    wait_done();
    check_dest("rerun", 36'h5A40, 0, test_lines);
    check_untouched("rerun", 36'h5A40);
    if (hs_count <= hs_mark) abort_run("no memory handshakes were seen after the reset");
  endtask

  // ##################################################
  // Sequence, bus monitor and watchdog
  always @(posedge viol) abort_run("memory model saw a malformed handshake");

  initial begin
    #(run_count * test_lines * cycles_per_line * clk_period);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    go        = 1'b0;
    wr_offset = '0;
    soft_rst  = 1'b0;
    @(negedge por_rst);
    test_full_copy();
    test_high_merge();
    test_low_merge();
    test_untouched();
    test_reset_rerun();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_test_top.f ====
common/cache_test_pkg.sv
tester/cache_tester_sm.sv
cache/cache_array.sv
cache/cache_ctrl.sv
logic/cache_test_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_model.sv
sim/cache_test_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module cache_test_tb \
  -f cache_test_top.f -Mdir obj_dir > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vcache_test_tb > sim.log 2>&1

grep -q "Testbench failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation OK"
